/* common/pwm_pkg.sv */
// PWM subsystem shared definitions
package pwm_pkg;

    localparam int AXIL_ADDR_WIDTH = 32;
    localparam int AXIL_DATA_WIDTH = 32;
    localparam int PWM_WIDTH = 16;

    // Bus level types
    typedef logic [AXIL_ADDR_WIDTH-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_WIDTH-1:0] axil_data_t;
    typedef logic [AXIL_DATA_WIDTH/8-1:0] axil_strb_t;
    typedef logic [1:0] axil_resp_t;

    // Carrier count, period and duty share one width
    typedef logic [PWM_WIDTH-1:0] pwm_count_t;

    // Master to slave
    typedef struct packed {
        logic aw_valid;
        axil_addr_t aw_addr;
        logic w_valid;
        axil_data_t w_data;
        axil_strb_t w_strb;
        logic b_ready;
        logic ar_valid;
        axil_addr_t ar_addr;
        logic r_ready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic aw_ready;
        logic w_ready;
        logic b_valid;
        axil_resp_t b_resp;
        logic ar_ready;
        logic r_valid;
        axil_data_t r_data;
        axil_resp_t r_resp;
    } axil_rsp_t;

    // Register map in word indices from the base address
    localparam int REG_CONTROL = 0;
    localparam int REG_PERIOD = 1;
    localparam int REG_DUTY_BASE = 2;

    localparam int CONTROL_ENABLE_BIT = 0;

    localparam axil_resp_t RESP_OKAY = 2'b00;

endpackage

/* src/axil_skid_buffer.sv */
// AXI channel skid buffer
`timescale 1ns/10ps

module axil_skid_buffer #(
    parameter int DATA_WIDTH = 32
) (
    input logic clock,
    input logic reset,
    input logic in_valid,
    output logic in_ready,
    input logic [DATA_WIDTH-1:0] in_data,
    output logic out_valid,
    input logic out_ready,
    output logic [DATA_WIDTH-1:0] out_data
);

    typedef enum logic [1:0] {
        EMPTY,
        ONE,
        FULL
    } state_t;

    state_t state;
    state_t state_next;
    logic [DATA_WIDTH-1:0] spill_data;
    logic push;
    logic pop;

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;
    assign out_valid = (state != EMPTY);

    always_comb begin
        state_next = state;
        case (state)
            EMPTY: if (push) state_next = ONE;
            ONE: begin
                if (push && !pop) begin
                    state_next = FULL;
                end else if (!push && pop) begin
                    state_next = EMPTY;
                end
            end
            FULL: if (pop) state_next = ONE;
            default: state_next = EMPTY;
        endcase
    end

    // Ready comes from a flop so the upstream path is cut
    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= EMPTY;
            in_ready <= 1'b0;
        end else begin
            state <= state_next;
            in_ready <= (state_next != FULL);
        end
    end

    always_ff @(posedge clock) begin
        if (state == FULL) begin
            if (pop) out_data <= spill_data;
        end else if (push && (state == EMPTY || pop)) begin
            out_data <= in_data;
        end
        // Second entry parks here while the output is stalled
        if (state == ONE && push && !pop) spill_data <= in_data;
    end

endmodule

/* register_cu/axil_register_cu.sv */
// AXI4-Lite register control unit
`timescale 1ns/10ps

module axil_register_cu
    import pwm_pkg::*;
#(
    parameter int N_CHANNELS = 2,
    parameter axil_addr_t BASE_ADDRESS = '0
) (
    input logic clock,
    input logic reset,
    input axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output logic enable,
    output pwm_count_t period,
    output pwm_count_t duty [N_CHANNELS],
    input pwm_count_t count,
    input axil_data_t periods
);

    // Status words follow the duty registers
    localparam int N_CONFIG = REG_DUTY_BASE + N_CHANNELS;
    localparam int REG_COUNT = N_CONFIG;
    localparam int REG_PERIODS = N_CONFIG + 1;
    localparam int INDEX_WIDTH = $clog2(N_CONFIG);

    logic aw_ready;
    logic w_ready;
    logic ar_ready;
    logic aw_valid_q;
    logic w_valid_q;
    logic ar_valid_q;
    axil_addr_t aw_addr_q;
    axil_addr_t ar_addr_q;
    axil_data_t w_data_q;
    axil_strb_t w_strb_q;

    logic b_valid;
    logic r_valid;
    axil_data_t r_data;
    logic write_fire;
    logic read_fire;
    axil_addr_t write_index;
    axil_addr_t read_index;
    axil_data_t read_word;
    axil_data_t config_regs [N_CONFIG];

    function automatic axil_data_t apply_strobe(
        input axil_data_t prior,
        input axil_data_t new_data,
        input axil_strb_t strb
    );
        axil_data_t merged;
        merged = prior;
        for (int k = 0; k < AXIL_DATA_WIDTH / 8; k++) begin
            if (strb[k]) merged[k*8 +: 8] = new_data[k*8 +: 8];
        end
        return merged;
    endfunction

    axil_skid_buffer #(
        .DATA_WIDTH(AXIL_ADDR_WIDTH)
    ) u_aw_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(axil_req.aw_valid),
        .in_ready(aw_ready),
        .in_data(axil_req.aw_addr),
        .out_valid(aw_valid_q),
        .out_ready(write_fire),
        .out_data(aw_addr_q)
    );

    axil_skid_buffer #(
        .DATA_WIDTH(AXIL_DATA_WIDTH + AXIL_DATA_WIDTH / 8)
    ) u_w_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(axil_req.w_valid),
        .in_ready(w_ready),
        .in_data({axil_req.w_data, axil_req.w_strb}),
        .out_valid(w_valid_q),
        .out_ready(write_fire),
        .out_data({w_data_q, w_strb_q})
    );

    axil_skid_buffer #(
        .DATA_WIDTH(AXIL_ADDR_WIDTH)
    ) u_ar_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(axil_req.ar_valid),
        .in_ready(ar_ready),
        .in_data(axil_req.ar_addr),
        .out_valid(ar_valid_q),
        .out_ready(read_fire),
        .out_data(ar_addr_q)
    );

    // Both write entries leave together once B is free
    assign write_fire = aw_valid_q && w_valid_q && (!b_valid || axil_req.b_ready);
    assign read_fire = ar_valid_q && (!r_valid || axil_req.r_ready);

    assign write_index = (aw_addr_q - BASE_ADDRESS) >> 2;
    assign read_index = (ar_addr_q - BASE_ADDRESS) >> 2;

    // Indices past the map are acknowledged but dropped
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < N_CONFIG; i++) config_regs[i] <= '0;
        end else if (write_fire && write_index < axil_addr_t'(N_CONFIG)) begin
            config_regs[write_index[INDEX_WIDTH-1:0]] <=
                apply_strobe(config_regs[write_index[INDEX_WIDTH-1:0]], w_data_q, w_strb_q);
        end
    end

    always_comb begin
        read_word = '0;
        if (read_index < axil_addr_t'(N_CONFIG)) begin
            read_word = config_regs[read_index[INDEX_WIDTH-1:0]];
        end else if (read_index == axil_addr_t'(REG_COUNT)) begin
            read_word = axil_data_t'(count);
        end else if (read_index == axil_addr_t'(REG_PERIODS)) begin
            read_word = periods;
        end
    end

    // Responses hold until the master takes them
    always_ff @(posedge clock) begin
        if (!reset) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (write_fire) begin
                b_valid <= 1'b1;
            end else if (axil_req.b_ready) begin
                b_valid <= 1'b0;
            end
            if (read_fire) begin
                r_valid <= 1'b1;
            end else if (axil_req.r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (read_fire) r_data <= read_word;
    end

    assign axil_rsp = '{
        aw_ready: aw_ready,
        w_ready: w_ready,
        b_valid: b_valid,
        b_resp: RESP_OKAY,
        ar_ready: ar_ready,
        r_valid: r_valid,
        r_data: r_data,
        r_resp: RESP_OKAY
    };

    assign enable = config_regs[REG_CONTROL][CONTROL_ENABLE_BIT];
    assign period = config_regs[REG_PERIOD][PWM_WIDTH-1:0];

    always_comb begin
        for (int i = 0; i < N_CHANNELS; i++) begin
            duty[i] = config_regs[REG_DUTY_BASE + i][PWM_WIDTH-1:0];
        end
    end

endmodule

/* pwm/pwm_carrier.sv */
// Sawtooth carrier counter
`timescale 1ns/10ps

module pwm_carrier
    import pwm_pkg::*;
(
    input logic clock,
    input logic reset,
    input logic enable,
    input pwm_count_t period,
    output pwm_count_t count,
    output logic wrap,
    output axil_data_t periods
);

    logic running;
    pwm_count_t last_count;

    assign running = enable && (period != '0);
    assign last_count = period - pwm_count_t'(1);

    // Greater-or-equal also catches a period shortened below the running count
    assign wrap = running && (count >= last_count);

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
        end else if (!running || wrap) begin
            count <= '0;
        end else begin
            count <= count + pwm_count_t'(1);
        end
    end

    // Count of completed periods wraps around freely
    always_ff @(posedge clock) begin
        if (!reset) begin
            periods <= '0;
        end else if (wrap) begin
            periods <= periods + axil_data_t'(1);
        end
    end

endmodule

/* pwm/pwm_compare_bank.sv */
// PWM duty comparator bank
`timescale 1ns/10ps

module pwm_compare_bank
    import pwm_pkg::*;
#(
    parameter int N_CHANNELS = 2
) (
    input logic clock,
    input logic reset,
    input logic enable,
    input pwm_count_t count,
    input logic wrap,
    input pwm_count_t duty [N_CHANNELS],
    output logic [N_CHANNELS-1:0] pwm_out
);

    pwm_count_t shadow_duty [N_CHANNELS];

    // New duty takes effect at the period boundary only
    always_ff @(posedge clock) begin
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (wrap || !enable) shadow_duty[i] <= duty[i];
        end
    end

    // Registered compare keeps the outputs clean
    always_ff @(posedge clock) begin
        if (!reset) begin
            pwm_out <= '0;
        end else begin
            for (int i = 0; i < N_CHANNELS; i++) begin
                pwm_out[i] <= enable && (count < shadow_duty[i]);
            end
        end
    end

endmodule

/* src/pwm_subsystem.sv */
// PWM subsystem top level
`timescale 1ns/10ps

module pwm_subsystem
    import pwm_pkg::*;
#(
    parameter int N_CHANNELS = 2,
    parameter axil_addr_t BASE_ADDRESS = '0
) (
    input logic clock,
    input logic reset,
    input axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output logic [N_CHANNELS-1:0] pwm_out
);

    logic enable;
    logic wrap;
    pwm_count_t period;
    pwm_count_t count;
    pwm_count_t duty [N_CHANNELS];
    axil_data_t periods;

    axil_register_cu #(
        .N_CHANNELS(N_CHANNELS),
        .BASE_ADDRESS(BASE_ADDRESS)
    ) u_register_cu (
        .clock(clock),
        .reset(reset),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .enable(enable),
        .period(period),
        .duty(duty),
        .count(count),
        .periods(periods)
    );

    pwm_carrier u_carrier (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .period(period),
        .count(count),
        .wrap(wrap),
        .periods(periods)
    );

    pwm_compare_bank #(
        .N_CHANNELS(N_CHANNELS)
    ) u_compare_bank (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .count(count),
        .wrap(wrap),
        .duty(duty),
        .pwm_out(pwm_out)
    );

endmodule

/* dv/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int CLOCK_PERIOD = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Reset is active low and released on a rising edge
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b1;
    end

endmodule

/* dv/tb_pwm_checks.sv */
// PWM high time monitor
`timescale 1ns/10ps

module tb_pwm_checks
    import pwm_pkg::*;
#(
    parameter int N_CHANNELS = 2
) (
    input logic clock,
    input logic [N_CHANNELS-1:0] pwm_out,
    input logic start,
    input pwm_count_t window,
    output pwm_count_t high_time [N_CHANNELS],
    output logic done
);

    pwm_count_t remaining;
    pwm_count_t tally [N_CHANNELS];

    initial begin
        done = 1'b0;
        remaining = '0;
    end

    // One sample per rising edge over the requested window
    always @(posedge clock) begin
        if (start) begin
            remaining <= window;
            done <= 1'b0;
            for (int i = 0; i < N_CHANNELS; i++) tally[i] <= '0;
        end else if (remaining != '0) begin
            remaining <= remaining - pwm_count_t'(1);
            for (int i = 0; i < N_CHANNELS; i++) begin
                tally[i] <= tally[i] + pwm_count_t'(pwm_out[i]);
            end
            if (remaining == pwm_count_t'(1)) begin
                done <= 1'b1;
                for (int i = 0; i < N_CHANNELS; i++) begin
                    high_time[i] <= tally[i] + pwm_count_t'(pwm_out[i]);
                end
            end
        end
    end

endmodule

/* dv/tb_pwm_subsystem.sv */
// PWM subsystem testbench
`timescale 1ns/10ps

module tb_pwm_subsystem
    import pwm_pkg::*;
;

    localparam int CLOCK_PERIOD = 40;
    localparam int N_CHANNELS = 2;
    localparam axil_addr_t BASE_ADDRESS = '0;
    localparam int RANDOM_SEED = 32'hce04;
    localparam int N_CONFIG = REG_DUTY_BASE + N_CHANNELS;
    localparam int REG_COUNT = N_CONFIG;
    localparam int REG_PERIODS = N_CONFIG + 1;
    localparam int N_RANDOM = 200;
    localparam int N_SETTINGS = 10;
    localparam int MAX_PERIOD = 60;
    localparam int N_OUT_OF_RANGE = 10;
    localparam int STATUS_WAIT = 3 * MAX_PERIOD + 4;
    localparam int N_TRANSACTIONS = (N_CONFIG + 2) + 2 * N_RANDOM + 1
        + N_SETTINGS * (N_CHANNELS + 1) + 7 + 2 * N_OUT_OF_RANGE + N_CONFIG;
    localparam int PWM_CYCLES = N_SETTINGS * (3 * MAX_PERIOD + 4) + 2 * STATUS_WAIT;
    localparam int WATCHDOG_CYCLES = N_TRANSACTIONS * 20 + PWM_CYCLES;

    logic clock;
    logic reset;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    logic [N_CHANNELS-1:0] pwm_out;
    logic window_start;
    pwm_count_t window;
    pwm_count_t high_time [N_CHANNELS];
    logic window_done;
    axil_data_t config_model [N_CONFIG];

    tb_clock_gen #(
        .CLOCK_PERIOD(CLOCK_PERIOD),
        .RESET_CYCLES(4)
    ) u_clock_gen (
        .clock(clock),
        .reset(reset)
    );

    pwm_subsystem #(
        .N_CHANNELS(N_CHANNELS),
        .BASE_ADDRESS(BASE_ADDRESS)
    ) u_pwm_subsystem (
        .clock(clock),
        .reset(reset),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .pwm_out(pwm_out)
    );

    tb_pwm_checks #(
        .N_CHANNELS(N_CHANNELS)
    ) u_checks (
        .clock(clock),
        .pwm_out(pwm_out),
        .start(window_start),
        .window(window),
        .high_time(high_time),
        .done(window_done)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic compare_data(input string name, input axil_data_t expected,
                                input axil_data_t actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("ERROR at %0t: %s expected %h, got %h",
                $time, name, expected, actual));
        end
    endtask

    task automatic compare_resp(input string name, input axil_resp_t expected,
                                input axil_resp_t actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("ERROR at %0t: %s expected %b, got %b",
                $time, name, expected, actual));
        end
    endtask

    task automatic compare_high_time(input string name, input pwm_count_t expected,
                                     input pwm_count_t actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("ERROR at %0t: %s expected %0d, got %0d",
                $time, name, expected, actual));
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("ERROR at %0t: %s expected %b, got %b",
                $time, name, expected, actual));
        end
    endtask

    // Byte lanes selected by the strobe take the new data
    function automatic axil_data_t merge_strobe(input axil_data_t prior,
                                                input axil_data_t data,
                                                input axil_strb_t strb);
        axil_data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (prior & ~mask) | (data & mask);
    endfunction

    function automatic axil_addr_t word_address(input int index);
        return BASE_ADDRESS + axil_addr_t'(index) * 4;
    endfunction

    task automatic write_reg(input int index, input axil_data_t data, input axil_strb_t strb);
        int aw_wait;
        int w_wait;
        int hold;
        bit aw_sent;
        bit w_sent;
        aw_wait = $urandom_range(0, 3);
        w_wait = $urandom_range(0, 3);
        hold = $urandom_range(0, 5);
        aw_sent = 1'b0;
        w_sent = 1'b0;
        while (!aw_sent || !w_sent) begin
            @(posedge clock);
            if (!aw_sent) begin
                if (axil_req.aw_valid && axil_rsp.aw_ready) begin
                    aw_sent = 1'b1;
                    axil_req.aw_valid <= 1'b0;
                end else if (aw_wait == 0) begin
                    axil_req.aw_valid <= 1'b1;
                    axil_req.aw_addr <= word_address(index);
                end else begin
                    aw_wait--;
                end
            end
            if (!w_sent) begin
                if (axil_req.w_valid && axil_rsp.w_ready) begin
                    w_sent = 1'b1;
                    axil_req.w_valid <= 1'b0;
                end else if (w_wait == 0) begin
                    axil_req.w_valid <= 1'b1;
                    axil_req.w_data <= data;
                    axil_req.w_strb <= strb;
                end else begin
                    w_wait--;
                end
            end
        end
        while (!axil_rsp.b_valid) @(posedge clock);
        // Response must hold while b_ready is low
        repeat (hold) begin
            @(posedge clock);
            compare_flag("b_valid", 1'b1, axil_rsp.b_valid);
        end
        axil_req.b_ready <= 1'b1;
        @(posedge clock);
        compare_resp("b_resp", RESP_OKAY, axil_rsp.b_resp);
        axil_req.b_ready <= 1'b0;
        @(posedge clock);
        compare_flag("b_valid after handshake", 1'b0, axil_rsp.b_valid);
    endtask

    task automatic read_reg(input int index, output axil_data_t data);
        int ar_wait;
        int hold;
        bit ar_sent;
        ar_wait = $urandom_range(0, 3);
        hold = $urandom_range(0, 5);
        ar_sent = 1'b0;
        while (!ar_sent) begin
            @(posedge clock);
            if (axil_req.ar_valid && axil_rsp.ar_ready) begin
                ar_sent = 1'b1;
                axil_req.ar_valid <= 1'b0;
            end else if (ar_wait == 0) begin
                axil_req.ar_valid <= 1'b1;
                axil_req.ar_addr <= word_address(index);
            end else begin
                ar_wait--;
            end
        end
        while (!axil_rsp.r_valid) @(posedge clock);
        data = axil_rsp.r_data;
        repeat (hold) begin
            @(posedge clock);
            compare_flag("r_valid", 1'b1, axil_rsp.r_valid);
            compare_data("r_data while stalled", data, axil_rsp.r_data);
        end
        axil_req.r_ready <= 1'b1;
        @(posedge clock);
        compare_resp("r_resp", RESP_OKAY, axil_rsp.r_resp);
        axil_req.r_ready <= 1'b0;
        @(posedge clock);
        compare_flag("r_valid after handshake", 1'b0, axil_rsp.r_valid);
    endtask

    task automatic write_model(input int index, input axil_data_t data, input axil_strb_t strb);
        write_reg(index, data, strb);
        config_model[index] = merge_strobe(config_model[index], data, strb);
    endtask

    task automatic check_reset_state();
        axil_data_t value;
        compare_flag("aw_ready", 1'b0, axil_rsp.aw_ready);
        compare_flag("w_ready", 1'b0, axil_rsp.w_ready);
        compare_flag("ar_ready", 1'b0, axil_rsp.ar_ready);
        compare_flag("b_valid", 1'b0, axil_rsp.b_valid);
        compare_flag("r_valid", 1'b0, axil_rsp.r_valid);
        for (int c = 0; c < N_CHANNELS; c++) begin
            compare_flag($sformatf("pwm_out[%0d]", c), 1'b0, pwm_out[c]);
        end
        for (int i = 0; i <= REG_PERIODS; i++) begin
            read_reg(i, value);
            compare_data($sformatf("r_data of index %0d after reset", i), '0, value);
        end
    endtask

    task automatic check_readback();
        int index;
        axil_data_t data;
        axil_strb_t strb;
        axil_data_t value;
        for (int n = 0; n < N_RANDOM; n++) begin
            index = $urandom_range(0, N_CONFIG - 1);
            data = $urandom();
            strb = axil_strb_t'($urandom_range(0, 15));
            write_model(index, data, strb);
            read_reg(index, value);
            compare_data($sformatf("r_data of index %0d", index), config_model[index], value);
        end
    endtask

    task automatic check_duty_cycle();
        pwm_count_t period;
        pwm_count_t duty [N_CHANNELS];
        pwm_count_t expected;
        write_model(REG_CONTROL, 32'h1, 4'hf);
        for (int s = 0; s < N_SETTINGS; s++) begin
            period = pwm_count_t'($urandom_range(4, MAX_PERIOD));
            write_model(REG_PERIOD, axil_data_t'(period), 4'hf);
            for (int c = 0; c < N_CHANNELS; c++) begin
                duty[c] = pwm_count_t'($urandom_range(0, period + 5));
                write_model(REG_DUTY_BASE + c, axil_data_t'(duty[c]), 4'hf);
            end
            // Shadow duties settle within two periods
            repeat (2 * period + 2) @(posedge clock);
            window <= period;
            window_start <= 1'b1;
            @(posedge clock);
            window_start <= 1'b0;
            do @(posedge clock); while (!window_done);
            for (int c = 0; c < N_CHANNELS; c++) begin
                expected = (duty[c] < period) ? duty[c] : period;
                compare_high_time($sformatf("high time of pwm_out[%0d]", c), expected,
                    high_time[c]);
            end
        end
    endtask

    task automatic check_status();
        axil_data_t first;
        axil_data_t second;
        axil_data_t current;
        axil_data_t period;
        period = axil_data_t'(config_model[REG_PERIOD][PWM_WIDTH-1:0]);
        read_reg(REG_PERIODS, first);
        repeat (STATUS_WAIT) @(posedge clock);
        read_reg(REG_PERIODS, second);
        if (second <= first) begin
            stop_with_failure("Completed period count did not rise while enabled");
        end
        read_reg(REG_COUNT, current);
        if (current >= period) begin
            stop_with_failure("Carrier count read back at or above the period");
        end
        write_model(REG_CONTROL, 32'h0, 4'hf);
        read_reg(REG_PERIODS, first);
        repeat (STATUS_WAIT) @(posedge clock);
        read_reg(REG_PERIODS, second);
        compare_data("r_data of completed periods while disabled", first, second);
        read_reg(REG_COUNT, current);
        compare_data("r_data of carrier count while disabled", '0, current);
    endtask

    task automatic check_out_of_range();
        int index;
        axil_data_t value;
        for (int n = 0; n < N_OUT_OF_RANGE; n++) begin
            index = $urandom_range(REG_PERIODS + 1, 255);
            write_reg(index, $urandom(), axil_strb_t'($urandom_range(1, 15)));
            read_reg(index, value);
            compare_data($sformatf("r_data of unmapped index %0d", index), '0, value);
        end
        for (int i = 0; i < N_CONFIG; i++) begin
            read_reg(i, value);
            compare_data($sformatf("r_data of index %0d", i), config_model[i], value);
        end
    endtask

    initial begin
        axil_req = '0;
        window_start = 1'b0;
        window = '0;
        for (int i = 0; i < N_CONFIG; i++) config_model[i] = '0;
        void'($urandom(RANDOM_SEED));
        @(posedge reset);
        @(posedge clock);
        check_reset_state();
        check_readback();
        check_duty_cycle();
        check_status();
        check_out_of_range();
        $display("All tests passed!");
        $finish;
    end

    // Watchdog sized from the transaction count and PWM windows
    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        stop_with_failure($sformatf("Watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

endmodule

/* tb.f */
common/pwm_pkg.sv
src/axil_skid_buffer.sv
register_cu/axil_register_cu.sv
pwm/pwm_carrier.sv
pwm/pwm_compare_bank.sv
src/pwm_subsystem.sv
dv/tb_clock_gen.sv
dv/tb_pwm_checks.sv
dv/tb_pwm_subsystem.sv

/* Makefile */
TOOL = verilator
FLAGS = --binary --timing -Wno-fatal -j 0
TOP = tb_pwm_subsystem
FILE_LIST = tb.f
BUILD_DIR = obj_dir
PASS_TEXT = All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
